//--- list.f
+incdir+design
design/ps2_kbd_pkg.sv
design/ps2_line_filter.sv
design/ps2_rx_frame.sv
design/scan_code_parser.sv
design/key_state_table.sv
design/ps2_keyboard.sv
test/tb_clock_gen.sv
test/ps2_keyboard_assert.sv
test/tb_ps2_keyboard.sv

//--- Makefile
# Verilator build for the PS/2 keyboard receiver

VERILATOR ?= verilator
FILELIST  ?= list.f
TOP       ?= tb_ps2_keyboard
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

# the run's exit status is masked by tee, the log decides
sim: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a pass line"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_ps2_keyboard.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_config.svh"

module tb_ps2_keyboard import ps2_kbd_pkg::*; ();

  localparam int          HALF_BIT       = 40;    // system cycles per PS/2 clock phase
  localparam int          BYTE_WAIT      = 2000;  // bound on one byte's result
  localparam int          BYTES_SENT     = 36;    // bytes over all tests
  localparam int          TIMEOUT_CYCLES = BYTES_SENT * BYTE_WAIT + 5000;
  localparam logic [31:0] SEED           = 32'd70891;

  logic                       clk;
  logic                       rst;
  logic                       ps2_clk;
  logic                       ps2_data;
  logic [`KEY_TABLE_SIZE-1:0] key_down;
  key_code_t                  last_change;
  logic                       key_valid;
  logic                       rx_err;

  logic [`KEY_TABLE_SIZE-1:0] exp_down;  // reference bitmap
  key_code_t                  exp_last;
  logic [31:0]                lfsr_state;
  int                         cycle_cnt = 0;
  logic [7:0]                 first_code;

  tb_clock_gen clock_i (
    .clk (clk),
    .rst (rst)
  );

  ps2_keyboard dut_i (
    .clk         (clk),
    .rst         (rst),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .key_down    (key_down),
    .last_change (last_change),
    .key_valid   (key_valid),
    .rx_err      (rx_err)
  );

  //////////////////////////////////////////////////
  // failure handling and compare tasks
  //////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  task automatic check_code(input string name, input key_code_t act, input key_code_t exp);
    if (act !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input int idx, input logic act, input logic exp);
    if (act !== exp) begin
      fail_run($sformatf("mismatch at %0t: key_down[%0d] expected %b actual %b",
                         $time, idx, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  task automatic check_table();
    for (int i = 0; i < `KEY_TABLE_SIZE; i++) begin
      check_bit(i, key_down[i], exp_down[i]);
    end
    check_code("last_change", last_change, exp_last);
  endtask

  //////////////////////////////////////////////////
  // random scan codes
  //////////////////////////////////////////////////

  function automatic logic take_bit();
    logic lsb;
    lsb        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'hD000_0001;  // galois taps 32,31,29,1
    end
    return lsb;
  endfunction

  function automatic logic [7:0] random_code();
    logic [7:0] b;
    do begin
      for (int i = 0; i < 8; i++) begin
        b[i] = take_bit();
      end
    end while (b == SCAN_BREAK || b == SCAN_EXTEND);  // prefixes are not key codes
    return b;
  endfunction

  //////////////////////////////////////////////////
  // PS/2 device model
  //////////////////////////////////////////////////

  task automatic send_byte(input logic [7:0] b, input logic bad_parity);
    logic [`PS2_FRAME_BITS-1:0] bits;
    logic                       par;
    par = ~^b;  // odd parity over data and parity bit
    if (bad_parity) begin
      par = ~par;
    end
    bits = {1'b1, par, b, 1'b0};
    for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
      ps2_data = bits[i];  // data moves while the bus clock is high
      repeat (HALF_BIT) @(negedge clk);
      ps2_clk = 1'b0;
      repeat (HALF_BIT) @(negedge clk);
      ps2_clk = 1'b1;
    end
  endtask

  task automatic wait_result(input logic expect_err);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < BYTE_WAIT) begin
      @(negedge clk);
      n++;
      if (key_valid || rx_err) begin
        seen = 1'b1;
        check_flag("rx_err", rx_err, expect_err);
        check_flag("key_valid", key_valid, !expect_err);
      end
    end
    if (!seen) begin
      fail_run($sformatf("no key_valid or rx_err within %0d cycles of the last byte", BYTE_WAIT));
    end
    @(negedge clk);
    check_flag("key_valid", key_valid, 1'b0);  // one cycle only
    check_flag("rx_err", rx_err, 1'b0);
  endtask

  task automatic watch_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_flag("key_valid", key_valid, 1'b0);
      check_flag("rx_err", rx_err, 1'b0);
    end
  endtask

  task automatic press_key(input logic ext, input logic [7:0] code);
    if (ext) begin
      send_byte(SCAN_EXTEND, 1'b0);
    end
    send_byte(code, 1'b0);
    wait_result(1'b0);
    exp_down[{ext, code}] = 1'b1;
    exp_last              = '{ext: ext, code: code};
    check_table();
  endtask

  task automatic release_key(input logic ext, input logic [7:0] code);
    if (ext) begin
      send_byte(SCAN_EXTEND, 1'b0);
    end
    send_byte(SCAN_BREAK, 1'b0);
    send_byte(code, 1'b0);
    wait_result(1'b0);
    exp_down[{ext, code}] = 1'b0;
    exp_last              = '{ext: ext, code: code};
    check_table();
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_idle();
    check_table();
    watch_quiet(300);  // bus idle, nothing may appear
  endtask

  task automatic test_make(output logic [7:0] c);
    c = random_code();
    press_key(1'b0, c);
  endtask

  task automatic test_break_stack(input logic [7:0] first);
    logic [7:0] held [8];
    logic [7:0] c;
    release_key(1'b0, first);
    for (int i = 0; i < 8; i++) begin
      c = random_code();
      while (exp_down[{1'b0, c}]) begin
        c = random_code();
      end
      held[i] = c;
      press_key(1'b0, c);
    end
    for (int i = 7; i >= 0; i--) begin
      release_key(1'b0, held[i]);  // reverse order, others stay held
    end
  endtask

  task automatic test_extended();
    logic [7:0] c;
    c = random_code();
    press_key(1'b1, c);
    release_key(1'b1, c);
  endtask

  task automatic test_bad_parity();
    logic [7:0] c;
    c = random_code();
    send_byte(c, 1'b1);
    wait_result(1'b1);
    watch_quiet(40);
    check_table();
  endtask

  task automatic test_break_discard();
    logic [7:0] c;
    c = random_code();
    while (exp_down[{1'b0, c}]) begin
      c = random_code();
    end
    send_byte(SCAN_BREAK, 1'b0);
    send_byte(c, 1'b1);  // bad frame drops the pending F0
    wait_result(1'b1);
    press_key(1'b0, c);
  endtask

  initial begin
    ps2_clk    = 1'b1;
    ps2_data   = 1'b1;
    exp_down   = '0;
    exp_last   = '0;
    lfsr_state = SEED;
    wait (rst === 1'b1);
    wait (rst === 1'b0);
    @(negedge clk);
    test_reset_idle();
    test_make(first_code);
    test_break_stack(first_code);
    test_extended();
    test_bad_parity();
    test_break_discard();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/ps2_keyboard_assert.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_config.svh"

module ps2_keyboard_assert (
  input logic                       clk,
  input logic                       rst,
  input logic                       rx_valid,
  input logic                       key_valid,
  input logic                       rx_err,
  input logic [`KEY_TABLE_SIZE-1:0] key_down
);

  // one event per completed scan code
  valid_single_a : assert property (@(posedge clk) disable iff (rst)
    key_valid |=> !key_valid)
    else $error("key_valid high two cycles in a row");

  // a bad frame never turns into a key event
  valid_err_excl_a : assert property (@(posedge clk) disable iff (rst)
    !(key_valid && rx_err))
    else $error("key_valid and rx_err high together");

  // bitmap moves with the key_valid pulse of a byte taken two cycles earlier
  down_on_valid_a : assert property (@(posedge clk) disable iff (rst)
    !$stable(key_down) |-> key_valid && $past(rx_valid, 2))
    else $error("key_down changed without key_valid following a received byte");

endmodule

bind ps2_keyboard ps2_keyboard_assert assert_i (
  .clk       (clk),
  .rst       (rst),
  .rx_valid  (rx_valid),
  .key_valid (key_valid),
  .rx_err    (rx_err),
  .key_down  (key_down)
);

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD  = 4;  // 8 ns clock
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // release away from the active edge
  end

endmodule

`default_nettype wire

//--- design/ps2_keyboard.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_config.svh"

module ps2_keyboard import ps2_kbd_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      ps2_clk,
  input  logic                      ps2_data,
  output logic [`KEY_TABLE_SIZE-1:0] key_down,
  output key_code_t                 last_change,
  output logic                      key_valid,
  output logic                      rx_err
);

  logic                   clk_level;
  logic                   data_level;
  logic [`PS2_BYTE_W-1:0] rx_byte;
  logic                   rx_valid;
  key_code_t              key_code;
  logic                   key_break;
  logic                   key_event;

  //////////////////////////////////////////////////
  // bus front end
  //////////////////////////////////////////////////

  ps2_line_filter clk_filter_i (
    .clk   (clk),
    .rst   (rst),
    .line  (ps2_clk),
    .level (clk_level)
  );

  ps2_line_filter data_filter_i (
    .clk   (clk),
    .rst   (rst),
    .line  (ps2_data),
    .level (data_level)
  );

  ps2_rx_frame rx_frame_i (
    .clk        (clk),
    .rst        (rst),
    .clk_level  (clk_level),
    .data_level (data_level),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .rx_err     (rx_err)
  );

  // decode and key state
  scan_code_parser parser_i (
    .clk       (clk),
    .rst       (rst),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .rx_err    (rx_err),
    .key_code  (key_code),
    .key_break (key_break),
    .key_event (key_event)
  );

  key_state_table table_i (
    .clk         (clk),
    .rst         (rst),
    .key_code    (key_code),
    .key_break   (key_break),
    .key_event   (key_event),
    .key_down    (key_down),
    .last_change (last_change),
    .key_valid   (key_valid)
  );

endmodule

`default_nettype wire

//--- design/key_state_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_config.svh"

module key_state_table import ps2_kbd_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  key_code_t                 key_code,
  input  logic                      key_break,
  input  logic                      key_event,
  output logic [`KEY_TABLE_SIZE-1:0] key_down,
  output key_code_t                 last_change,
  output logic                      key_valid
);

  logic [`KEY_CODE_W-1:0] key_idx;  // extended keys land in the upper half

  assign key_idx = key_code;

  //////////////////////////////////////////////////
  // held-key bitmap
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      key_down    <= '0;
      last_change <= '0;
      key_valid   <= 1'b0;
    end else begin
      key_valid <= key_event;
      if (key_event) begin
        key_down[key_idx] <= !key_break;  // make sets, break clears
        last_change       <= key_code;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/scan_code_parser.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_config.svh"

module scan_code_parser import ps2_kbd_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`PS2_BYTE_W-1:0] rx_byte,
  input  logic                   rx_valid,
  input  logic                   rx_err,
  output key_code_t              key_code,
  output logic                   key_break,
  output logic                   key_event
);

  parse_state_e state;
  logic         ext_pend;   // E0 seen for the code in progress
  logic         brk_pend;
  logic         is_break;
  logic         is_extend;
  logic         code_done;  // a non-prefix byte finishes the sequence

  assign is_break  = (rx_byte == SCAN_BREAK);
  assign is_extend = (rx_byte == SCAN_EXTEND);
  assign brk_pend  = (state == PARSE_GOT_BREAK);
  assign code_done = rx_valid && !is_break && !is_extend;

  //////////////////////////////////////////////////
  // prefix tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= PARSE_WAIT_CODE;
      ext_pend  <= 1'b0;
      key_event <= 1'b0;
    end else begin
      key_event <= code_done && !rx_err;
      if (rx_err) begin
        state    <= PARSE_WAIT_CODE;  // bad frame, drop any prefix
        ext_pend <= 1'b0;
      end else if (rx_valid) begin
        case (state)
          PARSE_WAIT_CODE, PARSE_GOT_EXTEND: begin
            if (is_break) begin
              state <= PARSE_GOT_BREAK;
            end else if (is_extend) begin
              state    <= PARSE_GOT_EXTEND;
              ext_pend <= 1'b1;
            end else begin
              state    <= PARSE_WAIT_CODE;
              ext_pend <= 1'b0;
            end
          end
          PARSE_GOT_BREAK: begin
            if (is_extend) begin
              ext_pend <= 1'b1;  // stays a break
            end else if (!is_break) begin
              state    <= PARSE_WAIT_CODE;
              ext_pend <= 1'b0;
            end
          end
          default: begin
            state    <= PARSE_WAIT_CODE;
            ext_pend <= 1'b0;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (code_done) begin
      key_code  <= '{ext: ext_pend, code: rx_byte};
      key_break <= brk_pend;
    end
  end

endmodule

`default_nettype wire

//--- design/ps2_rx_frame.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_config.svh"

module ps2_rx_frame import ps2_kbd_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   clk_level,
  input  logic                   data_level,
  output logic [`PS2_BYTE_W-1:0] rx_byte,
  output logic                   rx_valid,
  output logic                   rx_err
);

  localparam int BIT_CNT_W = $clog2(`PS2_FRAME_BITS + 1);

  rx_state_e                  state;
  logic [BIT_CNT_W-1:0]       bit_cnt;    // falling edges seen in this frame
  logic [`PS2_FRAME_BITS-1:0] frame;      // bit 0 is the start bit once full
  logic                       frame_done;
  logic                       frame_end;  // clock back high after the last bit
  logic                       parity_ok;

  assign frame_done = (bit_cnt == BIT_CNT_W'(`PS2_FRAME_BITS));
  assign frame_end  = (state == RX_CLK_LOW) && clk_level && frame_done;

  // data bits plus parity bit must hold an odd number of ones
  assign parity_ok = ^frame[`PS2_BYTE_W+1:1];

  //////////////////////////////////////////////////
  // bus FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= RX_IDLE;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
      case (state)
        RX_IDLE: begin
          bit_cnt <= '0;
          if (!clk_level) begin
            state <= RX_CLK_FALL;  // start bit edge
          end
        end
        RX_CLK_FALL: begin
          bit_cnt <= bit_cnt + 1'b1;
          state   <= RX_CLK_LOW;
        end
        RX_CLK_LOW: begin
          if (clk_level) begin
            if (frame_done) begin
              rx_valid <= parity_ok;
              rx_err   <= !parity_ok;
              state    <= RX_IDLE;
            end else begin
              state <= RX_CLK_HIGH;
            end
          end
        end
        RX_CLK_HIGH: begin
          if (!clk_level) begin
            state <= RX_CLK_FALL;
          end
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // shift register and output byte
  //////////////////////////////////////////////////

  // LSB first, so new bits enter at the top
  always_ff @(posedge clk) begin
    if (state == RX_CLK_FALL) begin
      frame <= {data_level, frame[`PS2_FRAME_BITS-1:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (frame_end && parity_ok) begin
      rx_byte <= frame[`PS2_BYTE_W:1];  // drop start bit
    end
  end

endmodule

`default_nettype wire

//--- design/ps2_line_filter.sv
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_config.svh"

module ps2_line_filter (
  input  logic clk,
  input  logic rst,
  input  logic line,
  output logic level
);

  localparam int DEBOUNCE = `PS2_DEBOUNCE_CYCLES;
  localparam int CNT_W    = $clog2(DEBOUNCE + 1);

  logic             cand;        // value the line is trying to settle at
  logic [CNT_W-1:0] stable_cnt;  // cycles cand has held

  // level only moves once cand has been steady for the full count;
  // any new edge on the line restarts the count
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cand       <= 1'b1;  // idle bus is high
      stable_cnt <= '0;
      level      <= 1'b1;
    end else if (line != cand) begin
      cand       <= line;
      stable_cnt <= '0;
    end else if (stable_cnt == CNT_W'(DEBOUNCE)) begin
      level <= cand;  // counter parks here until the next edge
    end else begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/ps2_kbd_pkg.sv
`default_nettype none

`include "ps2_kbd_config.svh"

package ps2_kbd_pkg;

  //////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    RX_IDLE     = 2'd0,  // bus idle, wait for clock low
    RX_CLK_FALL = 2'd1,  // one cycle, sample data here
    RX_CLK_LOW  = 2'd2,
    RX_CLK_HIGH = 2'd3
  } rx_state_e;

  typedef enum logic [1:0] {
    PARSE_WAIT_CODE  = 2'd0,
    PARSE_GOT_BREAK  = 2'd1,  // F0 seen
    PARSE_GOT_EXTEND = 2'd2   // E0 seen, no F0 yet
  } parse_state_e;

  // prefix bytes of set 2 scan codes
  typedef enum logic [`PS2_BYTE_W-1:0] {
    SCAN_EXTEND = 8'hE0,
    SCAN_BREAK  = 8'hF0
  } scan_byte_e;

  typedef struct packed {
    logic                   ext;   // code came after E0
    logic [`PS2_BYTE_W-1:0] code;
  } key_code_t;

endpackage

`default_nettype wire

//--- design/ps2_kbd_config.svh
`ifndef PS2_KBD_CONFIG_SVH
`define PS2_KBD_CONFIG_SVH

//////////////////////////////////////////////////
// line filter
//////////////////////////////////////////////////

// cycles a line must hold its value before the filter takes it
`define PS2_DEBOUNCE_CYCLES 15

//////////////////////////////////////////////////
// frame and key codes
//////////////////////////////////////////////////

// start, 8 data bits, parity, stop
`define PS2_FRAME_BITS 11
`define PS2_BYTE_W 8

// extend flag on top of the scan byte
`define KEY_CODE_W 9
`define KEY_TABLE_SIZE 512

`endif
